// File: logic/render_defs.svh
// Debug render parameters

`ifndef RENDER_DEFS_SVH
`define RENDER_DEFS_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------

// One screen coordinate, x or y
`define COORD_BITS 12

// Frame number kept by the register block
`define FRAME_BITS 16

// Shaded pixel count, wraps at 2^32
`define PIXEL_COUNT_BITS 32

// ------------------------------------------------------------------------
// Checkerboard selectors
// ------------------------------------------------------------------------

// Coordinate bit picking the square, so tiles are 32 pixels wide
`define TILE_BIT 5

// Frame bit picking the palette pair, which flips every 64 frames
`define PALETTE_BIT 6

`endif

// File: logic/render_pkg.sv
// Debug render types

`default_nettype none

`include "render_defs.svh"

package render_pkg;

    // ------------------------------------------------------------------------
    // Pixel data
    // ------------------------------------------------------------------------

    // 24-bit colour, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    // One coordinate handed to the shading core
    typedef struct packed {
        logic [`COORD_BITS-1:0] x;
        logic [`COORD_BITS-1:0] y;
    } surface_input_t;

    // Shaded pixel as it leaves the core, 48 bits
    typedef struct packed {
        logic [`COORD_BITS-1:0] x;
        logic [`COORD_BITS-1:0] y;
        rgb8_t                  color;
    } shade_output_t;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    // Screen size and run level from the register block
    typedef struct packed {
        logic [`COORD_BITS-1:0] width;
        logic [`COORD_BITS-1:0] height;
        logic                   enable;
    } render_state_t;

    // Debug core FSM
    typedef enum logic [1:0] {
        DCS_INIT,
        DCS_RENDER,
        DCS_DONE
    } debug_core_state_t;

endpackage

`default_nettype wire

// File: logic/render_config_regs.sv
// Render configuration registers

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module render_config_regs (
    input  wire                       clk,
    input  wire                       resetn,

    // Write port, one-cycle strobe
    input  wire                       cfg_write,
    input  wire  [1:0]                cfg_addr,
    input  wire  [15:0]               cfg_wdata,

    // Last pixel of a frame issued
    input  wire                       frame_done,

    output render_pkg::render_state_t rs,
    output logic [`FRAME_BITS-1:0]    frame_counter,
    output logic                      clear_pixels
);

    // Register map
    localparam logic [1:0] ADDR_WIDTH   = 2'd0;
    localparam logic [1:0] ADDR_HEIGHT  = 2'd1;
    localparam logic [1:0] ADDR_FRAME   = 2'd2;
    localparam logic [1:0] ADDR_CONTROL = 2'd3;

    logic frame_load;

    assign frame_load = cfg_write && (cfg_addr == ADDR_FRAME);

    // ------------------------------------------------------------------------
    // Render state and clear pulse
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rs           <= '0;
            clear_pixels <= 1'b0;
        end else begin
            clear_pixels <= 1'b0;
            if (cfg_write) begin
                case (cfg_addr)
                    ADDR_WIDTH:   rs.width  <= cfg_wdata[`COORD_BITS-1:0];
                    ADDR_HEIGHT:  rs.height <= cfg_wdata[`COORD_BITS-1:0];
                    ADDR_CONTROL: begin
                        rs.enable    <= cfg_wdata[0];
                        // Bit 1 is a command, never stored
                        clear_pixels <= cfg_wdata[1];
                    end
                    default: begin
                        // Frame counter load is handled below
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // Frame counter
    // ------------------------------------------------------------------------

    // A load in the same cycle as frame_done wins
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            frame_counter <= '0;
        end else if (frame_load) begin
            frame_counter <= cfg_wdata[`FRAME_BITS-1:0];
        end else if (frame_done) begin
            frame_counter <= frame_counter + 1'b1;
        end
    end

    // Scanner only finishes frames while rendering is enabled
    a_frame_done_enabled : assert property (
        @(posedge clk) disable iff (!resetn)
        frame_done |-> rs.enable
    );

endmodule

`default_nettype wire

// File: logic/pixel_scanner.sv
// Raster pixel scanner

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module pixel_scanner (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire render_pkg::render_state_t rs,

    // Core is working on a pixel
    input  wire                        busy,

    output logic                       add_input,
    output render_pkg::surface_input_t input_data,
    output logic                       frame_done
);

    logic [`COORD_BITS-1:0] x;
    logic [`COORD_BITS-1:0] y;
    logic [`COORD_BITS-1:0] last_x;
    logic [`COORD_BITS-1:0] last_y;
    logic                   at_last_x;
    logic                   at_last_y;
    logic                   issued;

    // ------------------------------------------------------------------------
    // Frame edges
    // ------------------------------------------------------------------------

    // Zero size behaves as a single row or column
    assign last_x = (rs.width == '0) ? '0 : rs.width - 1'b1;
    assign last_y = (rs.height == '0) ? '0 : rs.height - 1'b1;

    // Compare with >= so a shrink mid-frame still wraps
    assign at_last_x = (x >= last_x);
    assign at_last_y = (y >= last_y);

    // ------------------------------------------------------------------------
    // Issue
    // ------------------------------------------------------------------------

    // issued blocks a second strobe in the cycle busy is still rising
    assign add_input  = rs.enable && !busy && !issued;
    assign input_data = {x, y};
    assign frame_done = add_input && at_last_x && at_last_y;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            x      <= '0;
            y      <= '0;
            issued <= 1'b0;
        end else begin
            issued <= add_input;
            if (add_input) begin
                if (at_last_x) begin
                    x <= '0;
                    if (at_last_y) begin
                        y <= '0;
                    end else begin
                        y <= y + 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    // Every strobe is taken, so the core is busy on the next cycle
    a_issue_accepted : assert property (
        @(posedge clk) disable iff (!resetn)
        add_input |=> busy
    );

endmodule

`default_nettype wire

// File: logic/debug_core.sv
// Debug checkerboard shading core

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module debug_core (
    input  wire                         clk,
    input  wire                         resetn,

    // Accept strobe from the scanner
    input  wire                         add_input,
    input  wire render_pkg::surface_input_t input_data,
    input  wire  [`FRAME_BITS-1:0]      frame_counter,

    output logic                        busy,
    output logic                        valid,
    output render_pkg::shade_output_t   shade_out
);

    import render_pkg::*;

    debug_core_state_t      state;
    surface_input_t         pix_q;
    logic [`FRAME_BITS-1:0] frame_q;
    logic                   accept;
    logic                   tile_sel;
    logic                   palette_sel;
    rgb8_t                  color;

    assign accept = (state == DCS_INIT) && add_input;

    // Busy covers render and both done cycles
    assign busy = (state != DCS_INIT);

    // ------------------------------------------------------------------------
    // Colour select
    // ------------------------------------------------------------------------

    assign tile_sel    = pix_q.x[`TILE_BIT] ^ pix_q.y[`TILE_BIT];
    assign palette_sel = frame_q[`PALETTE_BIT];

    always_comb begin
        case ({palette_sel, tile_sel})
            2'b11:   color = '{r: 8'd255, g: 8'd0,   b: 8'd0};
            2'b10:   color = '{r: 8'd0,   g: 8'd255, b: 8'd0};
            2'b01:   color = '{r: 8'd255, g: 8'd255, b: 8'd0};
            default: color = '{r: 8'd0,   g: 8'd255, b: 8'd255};
        endcase
    end

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= DCS_INIT;
            valid <= 1'b0;
        end else begin
            case (state)
                DCS_INIT: begin
                    if (add_input) begin
                        state <= DCS_RENDER;
                    end
                end
                DCS_RENDER: begin
                    state <= DCS_DONE;
                end
                DCS_DONE: begin
                    // First cycle raises valid, second returns to init
                    if (!valid) begin
                        valid <= 1'b1;
                    end else begin
                        valid <= 1'b0;
                        state <= DCS_INIT;
                    end
                end
                default: begin
                    state <= DCS_INIT;
                    valid <= 1'b0;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            pix_q   <= input_data;
            frame_q <= frame_counter;
        end
        if (state == DCS_RENDER) begin
            shade_out <= '{x: pix_q.x, y: pix_q.y, color: color};
        end
    end

    // One-cycle valid, two edges after render
    a_valid_single : assert property (
        @(posedge clk) disable iff (!resetn)
        valid |=> !valid
    );

    a_valid_after_render : assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(valid) |-> ($past(state, 2) == DCS_RENDER)
    );

endmodule

`default_nettype wire

// File: logic/pixel_counter.sv
// Shaded pixel counter

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module pixel_counter (
    input  wire                            clk,
    input  wire                            resetn,

    // One-cycle clear from the control register
    input  wire                            clear_pixels,

    // Shaded pixel leaving the core
    input  wire                            valid,

    output logic [`PIXEL_COUNT_BITS-1:0]   pixel_counter
);

    // Clear beats a valid in the same cycle, count wraps
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pixel_counter <= '0;
        end else if (clear_pixels) begin
            pixel_counter <= '0;
        end else if (valid) begin
            pixel_counter <= pixel_counter + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/debug_render_top.sv
// Debug render top level

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module debug_render_top (
    input  wire                            clk,
    input  wire                            resetn,

    // Configuration writes
    input  wire                            cfg_write,
    input  wire  [1:0]                     cfg_addr,
    input  wire  [15:0]                    cfg_wdata,

    // Shaded pixel stream
    output logic                           busy,
    output logic                           pix_valid,
    output render_pkg::shade_output_t      pix_out,

    // Status
    output logic [`PIXEL_COUNT_BITS-1:0]   pixel_counter,
    output logic [`FRAME_BITS-1:0]         frame_counter
);

    import render_pkg::*;

    render_state_t  rs;
    surface_input_t input_data;
    logic           add_input;
    logic           frame_done;
    logic           clear_pixels;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    render_config_regs config_regs_inst (
        .clk           (clk),
        .resetn        (resetn),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .frame_done    (frame_done),
        .rs            (rs),
        .frame_counter (frame_counter),
        .clear_pixels  (clear_pixels)
    );

    pixel_scanner pixel_scanner_inst (
        .clk        (clk),
        .resetn     (resetn),
        .rs         (rs),
        .busy       (busy),
        .add_input  (add_input),
        .input_data (input_data),
        .frame_done (frame_done)
    );

    // ------------------------------------------------------------------------
    // Shading and count
    // ------------------------------------------------------------------------

    debug_core debug_core_inst (
        .clk           (clk),
        .resetn        (resetn),
        .add_input     (add_input),
        .input_data    (input_data),
        .frame_counter (frame_counter),
        .busy          (busy),
        .valid         (pix_valid),
        .shade_out     (pix_out)
    );

    pixel_counter pixel_counter_inst (
        .clk           (clk),
        .resetn        (resetn),
        .clear_pixels  (clear_pixels),
        .valid         (pix_valid),
        .pixel_counter (pixel_counter)
    );

endmodule

`default_nettype wire

// File: bench/debug_render_tb.sv
// Debug render testbench

`timescale 1ns/1ps
`default_nettype none

`include "render_defs.svh"

module debug_render_tb;

    import render_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int PIXEL_CYCLES  = 4;
    localparam int TOTAL_PIXELS  = (70 * 4 + 2) + 2 * (5 * 8 + 2) + 22 + 90 + 62;
    localparam int MARGIN_CYCLES = 1000;
    localparam int WATCHDOG_NS   = (TOTAL_PIXELS * PIXEL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic                           clk;
    logic                           resetn;
    logic                           cfg_write;
    logic [1:0]                     cfg_addr;
    logic [15:0]                    cfg_wdata;
    logic                           busy;
    logic                           pix_valid;
    shade_output_t                  pix_out;
    logic [`PIXEL_COUNT_BITS-1:0]   pixel_counter;
    logic [`FRAME_BITS-1:0]         frame_counter;

    // Reference model state
    logic [`COORD_BITS-1:0]         model_x;
    logic [`COORD_BITS-1:0]         model_y;
    logic [`COORD_BITS-1:0]         model_width;
    logic [`COORD_BITS-1:0]         model_height;
    logic [`COORD_BITS-1:0]         model_last_x;
    logic [`COORD_BITS-1:0]         model_last_y;
    logic [`FRAME_BITS-1:0]         model_frame;
    logic [`PIXEL_COUNT_BITS-1:0]   model_count;
    logic                           exp_tile;
    logic                           exp_palette;
    logic [23:0]                    exp_color;
    logic [1:0]                     tile_seen;
    logic [1:0]                     palette_seen;

    logic [31:0] lfsr;
    int          error_count;
    int          test_errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          valid_total;
    int          cycle_count;
    int          last_valid_cycle;
    int          gap;
    int          min_gap;

    debug_render_top debug_render_top_inst (
        .clk           (clk),
        .resetn        (resetn),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .busy          (busy),
        .pix_valid     (pix_valid),
        .pix_out       (pix_out),
        .pixel_counter (pixel_counter),
        .frame_counter (frame_counter)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Palette pair picked by p, square by t
    function automatic logic [23:0] expected_color(input logic p, input logic t);
        case ({p, t})
            2'b11:   return 24'hff0000;
            2'b10:   return 24'h00ff00;
            2'b01:   return 24'hffff00;
            default: return 24'h00ffff;
        endcase
    endfunction

    task automatic report_value(input string signal, input logic [47:0] expected,
                                input logic [47:0] actual);
        $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, signal, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string message);
        $display("At %0t ns: %s", $time, message);
        error_count++;
    endtask

    task automatic start_test();
        test_errors_at_start = error_count;
    endtask

    task automatic end_test(input int number, input string name);
        tests_run++;
        if (error_count == test_errors_at_start) begin
            $display("Test %0d %s: PASS", number, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL (%0d errors)", number, name,
                     error_count - test_errors_at_start);
        end
    endtask

    // Register write, model follows the stored value
    task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
        case (addr)
            2'd0:    model_width  = data[`COORD_BITS-1:0];
            2'd1:    model_height = data[`COORD_BITS-1:0];
            2'd2:    model_frame  = data[`FRAME_BITS-1:0];
            default: begin
            end
        endcase
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (busy && n < 20);
        if (busy) begin
            report_failure("core stayed busy after enable was cleared");
        end
    endtask

    task automatic wait_pixels(input int count);
        int target;
        int limit;
        int n;
        target = valid_total + count;
        limit  = count * PIXEL_CYCLES * 2 + 40;
        n      = 0;
        while (valid_total < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (valid_total < target) begin
            report_failure($sformatf("timed out waiting for %0d pixels", count));
        end
    endtask

    task automatic wait_frame(input logic [`FRAME_BITS-1:0] target, input int limit);
        int n;
        n = 0;
        while (model_frame != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (model_frame != target) begin
            report_failure("timed out waiting for the frame counter to advance");
        end
    endtask

    // ------------------------------------------------------------------------
    // Output monitor and model
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (resetn && pix_valid) begin
            exp_tile    = model_x[`TILE_BIT] ^ model_y[`TILE_BIT];
            exp_palette = model_frame[`PALETTE_BIT];
            exp_color   = expected_color(exp_palette, exp_tile);
            if (pix_out.x !== model_x) report_value("pix_out.x", model_x, pix_out.x);
            if (pix_out.y !== model_y) report_value("pix_out.y", model_y, pix_out.y);
            if (pix_out.color !== exp_color) begin
                report_value("pix_out.color", exp_color, pix_out.color);
            end
            if (busy !== 1'b1) report_value("busy", 1, busy);
            if (pixel_counter !== model_count) begin
                report_value("pixel_counter", model_count, pixel_counter);
            end
            if (valid_total > 0) begin
                gap = cycle_count - last_valid_cycle;
                if (gap < min_gap) min_gap = gap;
                if (gap < 3) report_value("pix_valid spacing", 3, gap);
            end
            last_valid_cycle = cycle_count;

            // Only squares and palettes drawn in the right colour count as seen
            if (pix_out.color === exp_color) begin
                tile_seen[exp_tile]       = 1'b1;
                palette_seen[exp_palette] = 1'b1;
            end

            // Raster step, zero size counts as one
            model_last_x = (model_width == '0) ? '0 : model_width - 1'b1;
            model_last_y = (model_height == '0) ? '0 : model_height - 1'b1;
            if (model_x >= model_last_x) begin
                model_x = '0;
                if (model_y >= model_last_y) begin
                    model_y     = '0;
                    model_frame = model_frame + 1'b1;
                end else begin
                    model_y = model_y + 1'b1;
                end
            end else begin
                model_x = model_x + 1'b1;
            end
            if (frame_counter !== model_frame) begin
                report_value("frame_counter", model_frame, frame_counter);
            end
            model_count = model_count + 1'b1;
            valid_total++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0]            rnd;
        int                     w;
        int                     h;
        int                     k;
        int                     snap;
        logic [`FRAME_BITS-1:0] base;

        clk          = 1'b0;
        resetn       = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = 2'd0;
        cfg_wdata    = 16'd0;
        lfsr         = 32'h7f366aff;
        model_x      = '0;
        model_y      = '0;
        model_width  = '0;
        model_height = '0;
        model_frame  = '0;
        model_count  = '0;
        tile_seen    = '0;
        palette_seen = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        valid_total  = 0;
        cycle_count  = 0;
        min_gap      = 1000;

        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        // Idle after reset
        start_test();
        repeat (50) begin
            @(negedge clk);
            if (pix_valid !== 1'b0) report_value("pix_valid", 0, pix_valid);
            if (busy !== 1'b0) report_value("busy", 0, busy);
        end
        if (pixel_counter !== '0) report_value("pixel_counter", 0, pixel_counter);
        if (frame_counter !== '0) report_value("frame_counter", 0, frame_counter);
        end_test(1, "reset idle");

        // One random frame
        start_test();
        random_bits(6, rnd);
        w = 33 + (rnd % 38);
        random_bits(2, rnd);
        h = 1 + rnd;
        tile_seen = '0;
        write_cfg(2'd0, w);
        write_cfg(2'd1, h);
        write_cfg(2'd3, 16'h0001);
        wait_pixels(w * h);
        write_cfg(2'd3, 16'h0000);
        wait_idle();
        if (tile_seen != 2'b11) report_failure("both checkerboard squares were not seen");
        if (frame_counter !== model_frame) begin
            report_value("frame_counter", model_frame, frame_counter);
        end
        end_test(2, "raster frame");

        // Frame loads just below the palette flips
        start_test();
        palette_seen = '0;
        for (int pass = 0; pass < 2; pass++) begin
            base = (pass == 0) ? 16'd64 : 16'd128;
            random_bits(2, rnd);
            w = 1 + rnd;
            random_bits(1, rnd);
            h = 1 + rnd;
            random_bits(2, rnd);
            k = 1 + (rnd % 3);
            write_cfg(2'd0, w);
            write_cfg(2'd1, h);
            write_cfg(2'd2, base - k);
            write_cfg(2'd3, 16'h0001);
            wait_frame(base + 1'b1, (k + 2) * w * h * PIXEL_CYCLES + 40);
            write_cfg(2'd3, 16'h0000);
            wait_idle();
            if (frame_counter !== model_frame) begin
                report_value("frame_counter", model_frame, frame_counter);
            end
        end
        if (palette_seen != 2'b11) report_failure("the palette pair never switched");
        end_test(3, "frame counter");

        // Clear and recount
        start_test();
        if (pixel_counter !== model_count) begin
            report_value("pixel_counter", model_count, pixel_counter);
        end
        write_cfg(2'd3, 16'h0002);
        model_count = '0;
        repeat (2) @(negedge clk);
        if (pixel_counter !== '0) report_value("pixel_counter", 0, pixel_counter);
        random_bits(4, rnd);
        write_cfg(2'd3, 16'h0001);
        wait_pixels(5 + rnd);
        write_cfg(2'd3, 16'h0000);
        wait_idle();
        if (pixel_counter !== model_count) begin
            report_value("pixel_counter", model_count, pixel_counter);
        end
        end_test(4, "pixel counter");

        // Pause in the middle of a frame
        start_test();
        write_cfg(2'd0, 16'd40);
        write_cfg(2'd1, 16'd3);
        write_cfg(2'd3, 16'h0001);
        random_bits(6, rnd);
        repeat (10 + rnd) @(posedge clk);
        write_cfg(2'd3, 16'h0000);
        snap = valid_total;
        repeat (20) @(negedge clk);
        if (valid_total - snap > 1) begin
            report_failure("pixels kept coming after enable was cleared");
        end
        write_cfg(2'd3, 16'h0001);
        wait_pixels(8);
        write_cfg(2'd3, 16'h0000);
        wait_idle();
        end_test(5, "pause and resume");

        // Full-rate stream
        start_test();
        min_gap = 1000;
        write_cfg(2'd3, 16'h0001);
        wait_pixels(60);
        write_cfg(2'd3, 16'h0000);
        wait_idle();
        if (min_gap < 3) report_value("pix_valid spacing", 3, min_gap);
        end_test(6, "spacing");

        $display("Tests run: %0d, failed: %0d, errors: %0d, pixels checked: %0d",
                 tests_run, tests_failed, error_count, valid_total);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/render_pkg.sv
logic/render_config_regs.sv
logic/pixel_scanner.sv
logic/debug_core.sv
logic/pixel_counter.sv
logic/debug_render_top.sv
bench/debug_render_tb.sv
